// File: build.f
+incdir+.
rxdp_pkg.sv
aib_bitsync.sv
aib_adaptrxdp_async_fifo.sv
aib_adaptrxdp_fifo.sv
aib_adaptrxdp_top.sv
tb_clkgen.sv
tb_rxdp.sv

// File: Makefile
# Verilator simulation of the receive datapath testbench

BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run tb_rxdp, pass if sim.log holds the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_rxdp -Mdir $(BUILD)
	./$(BUILD)/Vtb_rxdp | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf $(BUILD) sim.log

// File: tb_rxdp.sv
// Testbench for the receive datapath adapter
// Streams LFSR words into the DUT, predicts packed entries with a
// write-side model and checks data, flags and word-align errors
`timescale 1ns/1ps
`include "rxdp_defs.svh"

module tb_rxdp;

   import rxdp_pkg::*;

   localparam int DW          = `RXDP_DWIDTH;
   localparam int TEST_CYCLES = 624 + 9 * 10;           // Stream words plus resets
   localparam int WATCHDOG_NS = 10 * TEST_CYCLES * 100;

   logic        wr_clk;
   logic        rd_clk;
   logic        rst_n;                                  // Both domains
   logic [2:0]  rd_ratio;
   word_t       fifo_din;
   thr_t        r_pempty;
   thr_t        r_pfull;
   thr_t        r_empty;
   thr_t        r_full;
   fifo_mode_t  r_fifo_mode;
   rd_delay_t   r_phcomp_rd_delay;
   logic        r_wa_en;
   mkbit_t      r_mkbit;
   entry_t      fifo_dout;
   logic        fifo_empty;
   logic        fifo_pempty;
   logic        fifo_pfull;
   logic        fifo_full;
   logic        wa_error;
   errcnt_t     wa_error_cnt;
   logic        align_done;

   logic [31:0] lfsr_state = 32'h9df138b7;
   entry_t      model_q[$];                             // Predicted entries, oldest first
   entry_t      m_pack;                                 // Group being filled
   int          m_cnt;                                  // Next free lane
   logic        m_lock;
   logic        m_d0;                                   // Write enable stages
   logic        m_d1;
   logic        m_d2;
   errcnt_t     exp_cnt;
   logic        exp_err;
   logic        empty_hold;                             // fifo_empty must stay high
   logic        done_seen;
   time         done_t;
   time         release_t;
   time         rise2;
   time         rise7;
   int          n_checked;
   int          err_cnt = 0;
   int          n_tests = 0;
   int          n_pass  = 0;
   int          errs0;

   tb_clkgen clkgen0 (.ratio(rd_ratio), .wr_clk(wr_clk), .rd_clk(rd_clk));

   aib_adaptrxdp_top dut0 (
      .wr_clk (wr_clk), .wr_rst_n (rst_n), .fifo_din (fifo_din),
      .rd_clk (rd_clk), .rd_rst_n (rst_n),
      .r_pempty (r_pempty), .r_pfull (r_pfull), .r_empty (r_empty), .r_full (r_full),
      .r_fifo_mode (r_fifo_mode), .r_phcomp_rd_delay (r_phcomp_rd_delay),
      .r_wa_en (r_wa_en), .r_mkbit (r_mkbit), .fifo_dout (fifo_dout),
      .fifo_empty (fifo_empty), .fifo_pempty (fifo_pempty),
      .fifo_pfull (fifo_pfull), .fifo_full (fifo_full), .wa_error (wa_error),
      .wa_error_cnt (wa_error_cnt), .align_done (align_done)
   );

   // ****************************************
   // Helpers
   // ****************************************
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32, 22, 2, 1
   endfunction

   function automatic int top_lane(input fifo_mode_t mode);
      case (mode)
         `RXDP_MODE_2X: return 1;                       // Two-word groups
         `RXDP_MODE_4X: return 3;                       // Four-word groups
         default:       return 0;
      endcase
   endfunction

   // Bad unless marker only in the top lane of the mode
   function automatic logic bad_entry(input entry_t e);
      int   top;
      logic bad;
      top = top_lane(r_fifo_mode);
      if (!r_wa_en || top == 0)
         return 1'b0;
      bad = !e[top*DW + r_mkbit];
      for (int i = 0; i < top; i++)
         bad = bad | e[i*DW + r_mkbit];
      return bad;
   endfunction

   function automatic logic marker_wanted(input int kind, input int i);
      if (kind == 1)
         return (i % 4) == 3;                           // Every fourth word
      return ((i % 2 == 1) && (i % 6 != 5)) || (i > 0 && i % 80 == 0);
   endfunction

   task automatic draw_word(output word_t w);
      for (int b = 0; b < DW; b++) begin
         lfsr_state = lfsr_step(lfsr_state);
         w[b]       = lfsr_state[0];                    // One step per bit
      end
   endtask

   task automatic log_mismatch(input string msg);
      $display("[FAIL] t=%0d ns: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic report_problem(input string msg);
      $display("Error at %0d ns: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic end_test(input string name, input int errs_before);
      n_tests++;
      if (err_cnt == errs_before) begin
         n_pass++;
         $display("Test %0d %s: ok", n_tests, name);
      end else begin
         $display("Test %0d %s: failed with %0d errors", n_tests, name, err_cnt - errs_before);
      end
   endtask

   // ****************************************
   // Write-side model of packing and lock
   // ****************************************
   always @(posedge wr_clk) begin : write_model
      logic mark;
      int   lane;
      if (!rst_n) begin
         model_q.delete();
         m_pack = '0;
         m_cnt  = 0;
         m_lock = 1'b0;
         m_d0   = 1'b0;
         m_d1   = 1'b0;
         m_d2   = 1'b0;
      end else begin
         mark = r_wa_en && fifo_din[r_mkbit];
         if (m_d2 && r_fifo_mode != `RXDP_MODE_REG && (m_lock || !r_wa_en)) begin
            lane = mark ? top_lane(r_fifo_mode) : m_cnt; // Marker closes the group
            m_pack[lane*DW +: DW] = fifo_din;
            if (mark || m_cnt == top_lane(r_fifo_mode)) begin
               model_q.push_back(m_pack);
               m_pack = '0;
               m_cnt  = 0;
            end else begin
               m_cnt++;
            end
         end
         m_d2 = m_d1;
         m_d1 = m_d0;
         m_d0 = m_d0 || !r_wa_en || m_lock;             // Sticky after lock
         if (mark)
            m_lock = 1'b1;
      end
   end

   // ****************************************
   // Output checks, sampled on rd_clk fall
   // ****************************************
   always @(negedge rd_clk) begin : check_output
      entry_t want;
      if (!rst_n) begin
         exp_cnt   = '0;
         exp_err   = 1'b0;
         n_checked = 0;
         done_seen = 1'b0;
      end else begin
         assert (wa_error_cnt == exp_cnt)
            else log_mismatch($sformatf("wa_error_cnt %0d, expected %0d", wa_error_cnt, exp_cnt));
         assert (wa_error == exp_err)
            else log_mismatch($sformatf("wa_error %0b, expected %0b", wa_error, exp_err));
         assert (!empty_hold || fifo_empty) else log_mismatch("fifo_empty low at r_empty 15");
         assert (align_done || fifo_dout == '0) else log_mismatch("fifo_dout not zero while idle");
         assert (r_fifo_mode != `RXDP_MODE_REG || !align_done)
            else log_mismatch("align_done high in register mode");
         if (align_done) begin
            if (!done_seen) begin
               done_seen = 1'b1;
               done_t    = $time;                       // First valid entry
            end
            if (model_q.size() == 0) begin
               report_problem("an entry reached fifo_dout with none predicted");
            end else begin
               want = model_q.pop_front();
               assert (fifo_dout == want)
                  else log_mismatch($sformatf("entry %0d is %h, expected %h",
                                              n_checked, fifo_dout, want));
               n_checked++;
               if (bad_entry(want)) begin
                  exp_err = 1'b1;
                  if (exp_cnt != 4'hf)
                     exp_cnt = exp_cnt + 4'd1;          // Saturates
               end
            end
         end
      end
   end

   always @(negedge wr_clk)
      if (rst_n)
         assert (!fifo_full) else log_mismatch("fifo_full high with matched clock rates");

   // ****************************************
   // Stimulus
   // ****************************************
   task automatic apply_reset(input fifo_mode_t mode, input logic [2:0] ratio,
                              input logic wa_en, input rd_delay_t delay, input thr_t empty_thr);
      @(negedge wr_clk);
      rst_n             = 1'b0;
      empty_hold        = (empty_thr == 4'hf);
      r_fifo_mode       = mode;
      rd_ratio          = ratio;
      r_wa_en           = wa_en;
      r_phcomp_rd_delay = delay;
      r_empty           = empty_thr;
      fifo_din          = '0;
      repeat (2) @(posedge rd_clk);                     // Two slow-clock cycles
      @(negedge wr_clk);
      rst_n     = 1'b1;
      release_t = $time;
   endtask

   task automatic run_test(input fifo_mode_t mode, input logic [2:0] ratio, input logic wa_en,
                           input rd_delay_t delay, input thr_t empty_thr, input int kind,
                           input int nwords, output time rise);
      word_t w;
      apply_reset(mode, ratio, wa_en, delay, empty_thr);
      for (int i = 0; i < nwords; i++) begin
         draw_word(w);
         if (kind != 0)
            w[r_mkbit] = marker_wanted(kind, i);        // Marker by test intent
         fifo_din = w;
         @(negedge wr_clk);
      end
      if (mode != `RXDP_MODE_REG && n_checked == 0)
         report_problem("no entry reached fifo_dout during the stream");
      rise = done_seen ? done_t - release_t : 0;
   endtask

   initial begin
      rst_n             = 1'b0;
      rd_ratio          = 3'd1;
      fifo_din          = '0;
      r_pempty          = 4'd2;
      r_pfull           = 4'd12;
      r_empty           = 4'd0;
      r_full            = 4'hf;
      r_fifo_mode       = `RXDP_MODE_1X;
      r_phcomp_rd_delay = 4'd2;
      r_wa_en           = 1'b0;
      r_mkbit           = 7'd45;
      empty_hold        = 1'b0;

      errs0 = err_cnt;
      apply_reset(`RXDP_MODE_1X, 3'd1, 1'b0, 4'd2, 4'd0);
      assert (fifo_dout == '0 && !align_done && !wa_error && wa_error_cnt == '0 && fifo_empty)
         else log_mismatch("outputs after reset differ from reset values");
      // Empty FIFO sits below both partial thresholds
      assert (fifo_pempty && !fifo_pfull && !fifo_full)
         else log_mismatch("fill flags after reset differ from an empty FIFO");
      end_test("reset values", errs0);

      errs0 = err_cnt;
      run_test(`RXDP_MODE_1X, 3'd1, 1'b0, 4'd2, 4'd0, 0, 64, rise2);
      end_test("1x stream", errs0);

      errs0 = err_cnt;
      run_test(`RXDP_MODE_4X, 3'd4, 1'b1, 4'd2, 4'd0, 1, 128, rise2);
      assert (!wa_error) else log_mismatch("wa_error set on an aligned 4x stream");
      end_test("4x aligned", errs0);

      errs0 = err_cnt;
      run_test(`RXDP_MODE_2X, 3'd2, 1'b1, 4'd2, 4'd0, 2, 200, rise2);
      assert (wa_error && wa_error_cnt == 4'hf) else log_mismatch("wa_error_cnt not at 15");
      end_test("2x misaligned", errs0);

      errs0 = err_cnt;
      run_test(`RXDP_MODE_REG, 3'd1, 1'b0, 4'd2, 4'd0, 0, 40, rise2);
      end_test("register mode", errs0);

      errs0 = err_cnt;
      run_test(`RXDP_MODE_1X, 3'd1, 1'b0, 4'd2, 4'hf, 0, 64, rise2);
      end_test("empty threshold", errs0);

      errs0 = err_cnt;
      run_test(`RXDP_MODE_1X, 3'd1, 1'b0, 4'd2, 4'd0, 0, 64, rise2);
      end_test("read delay 2", errs0);

      errs0 = err_cnt;
      run_test(`RXDP_MODE_1X, 3'd1, 1'b0, 4'd7, 4'd0, 0, 64, rise7);
      end_test("read delay 7", errs0);

      errs0 = err_cnt;
      assert (rise2 > 0 && rise7 > rise2)
         else log_mismatch($sformatf("align_done rise %0d ns at delay 7, %0d ns at delay 2",
                                     rise7, rise2));
      end_test("read delay order", errs0);

      $display("Tests %0d, passed %0d, failed %0d, errors %0d",
               n_tests, n_pass, n_tests - n_pass, err_cnt);
      if (err_cnt == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout: tests did not finish within %0d ns", WATCHDOG_NS);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: tb_clkgen.sv
// Testbench clock source
// wr_clk at a fixed period, rd_clk divided from it by the rate ratio
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int WR_PERIOD = 100,          // wr_clk period in ns
   parameter int RD_PHASE  = 30            // rd_clk offset from time zero
) (
   input  logic [2:0] ratio,               // rd_clk period in wr_clk periods
   output logic       wr_clk,
   output logic       rd_clk
);

   int half_rd;                            // Current rd_clk half period

   initial begin
      wr_clk = 1'b0;
      forever begin
         #(WR_PERIOD / 2);
         wr_clk = ~wr_clk;
      end
   end

   // Ratio is read every half period, so a change takes effect at once
   initial begin
      rd_clk = 1'b0;
      #(RD_PHASE);
      forever begin
         half_rd = (ratio == 3'd0) ? WR_PERIOD / 2 : int'(ratio) * WR_PERIOD / 2;
         rd_clk  = ~rd_clk;
         #(half_rd);
      end
   end

endmodule

// File: aib_adaptrxdp_top.sv
// Receive datapath adapter top
// Subsystem boundary around the adapter FIFO
`timescale 1ns/1ps

module aib_adaptrxdp_top (
   input  logic                 wr_clk,            // Write clock
   input  logic                 wr_rst_n,          // Write reset
   input  rxdp_pkg::word_t      fifo_din,          // Link word in
   input  logic                 rd_clk,            // Read clock
   input  logic                 rd_rst_n,          // Read reset
   input  rxdp_pkg::thr_t       r_pempty,
   input  rxdp_pkg::thr_t       r_pfull,
   input  rxdp_pkg::thr_t       r_empty,
   input  rxdp_pkg::thr_t       r_full,
   input  rxdp_pkg::fifo_mode_t r_fifo_mode,       // 1x, 2x, 4x or register
   input  rxdp_pkg::rd_delay_t  r_phcomp_rd_delay, // Read tap select
   input  logic                 r_wa_en,           // Word align enable
   input  rxdp_pkg::mkbit_t     r_mkbit,           // Marker bit index
   output rxdp_pkg::entry_t     fifo_dout,         // Packed entry out
   output logic                 fifo_empty,
   output logic                 fifo_pempty,
   output logic                 fifo_pfull,
   output logic                 fifo_full,
   output logic                 wa_error,          // Sticky
   output rxdp_pkg::errcnt_t    wa_error_cnt,
   output logic                 align_done
);

   aib_adaptrxdp_fifo rxdp_fifo0 (
      .wr_clk            (wr_clk),
      .wr_rst_n          (wr_rst_n),
      .fifo_din          (fifo_din),
      .rd_clk            (rd_clk),
      .rd_rst_n          (rd_rst_n),
      .r_pempty          (r_pempty),
      .r_pfull           (r_pfull),
      .r_empty           (r_empty),
      .r_full            (r_full),
      .r_fifo_mode       (r_fifo_mode),
      .r_phcomp_rd_delay (r_phcomp_rd_delay),
      .r_wa_en           (r_wa_en),
      .r_mkbit           (r_mkbit),
      .fifo_dout         (fifo_dout),
      .fifo_empty        (fifo_empty),
      .fifo_pempty       (fifo_pempty),
      .fifo_pfull        (fifo_pfull),
      .fifo_full         (fifo_full),
      .wa_error          (wa_error),
      .wa_error_cnt      (wa_error_cnt),
      .align_done        (align_done)
   );

endmodule

// File: aib_adaptrxdp_fifo.sv
// Receive datapath adapter FIFO
// Builds the phase-comp write and read enables, registers the read
// entry and checks word alignment on the output
`timescale 1ns/1ps
`include "rxdp_defs.svh"

module aib_adaptrxdp_fifo (
   input  logic                 wr_clk,            // Write clock
   input  logic                 wr_rst_n,          // Write reset
   input  rxdp_pkg::word_t      fifo_din,          // Link word in
   input  logic                 rd_clk,            // Read clock
   input  logic                 rd_rst_n,          // Read reset
   input  rxdp_pkg::thr_t       r_pempty,          // Partial empty threshold
   input  rxdp_pkg::thr_t       r_pfull,           // Partial full threshold
   input  rxdp_pkg::thr_t       r_empty,           // Empty threshold
   input  rxdp_pkg::thr_t       r_full,            // Full threshold
   input  rxdp_pkg::fifo_mode_t r_fifo_mode,       // Rate mode
   input  rxdp_pkg::rd_delay_t  r_phcomp_rd_delay, // Read enable delay
   input  logic                 r_wa_en,           // Word align enable
   input  rxdp_pkg::mkbit_t     r_mkbit,           // Marker bit index
   output rxdp_pkg::entry_t     fifo_dout,         // Registered read entry
   output logic                 fifo_empty,        // Read domain
   output logic                 fifo_pempty,       // Read domain
   output logic                 fifo_pfull,        // Write domain
   output logic                 fifo_full,         // Write domain
   output logic                 wa_error,          // Sticky align error
   output rxdp_pkg::errcnt_t    wa_error_cnt,      // Saturating error count
   output logic                 align_done         // First valid entry marker
);

   import rxdp_pkg::*;

   logic       phcomp_mode;                    // Not register mode
   logic       wa_lock;                        // From async FIFO
   logic       phcomp_wren_d0;                 // Sticky write enable
   logic       phcomp_wren_d1;
   logic       phcomp_wren_d2;
   logic       phcomp_wren;                    // Delayed write enable
   logic       phcomp_wren_sync2;              // After bitsync
   logic [7:3] wren_sync_q;                    // Extra rd_clk stages
   logic       phcomp_rden;                    // Selected tap
   logic       wr_en;                          // Into async FIFO
   logic       rd_en;                          // Into async FIFO
   entry_t     fifo_rd_data;                   // Head entry
   entry_t     data_out;                       // Output register
   logic [3:0] lane_mk;                        // Marker bit per lane
   logic       bad_2x;
   logic       bad_4x;
   logic       wa_error_int;                   // Bad entry this cycle

   assign phcomp_mode = (r_fifo_mode != `RXDP_MODE_REG);

   // ****************************************
   // Write enable generation
   // ****************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         phcomp_wren_d0 <= 1'b0;
         phcomp_wren_d1 <= 1'b0;
         phcomp_wren_d2 <= 1'b0;
      end else begin
         phcomp_wren_d0 <= phcomp_wren_d0 | ~r_wa_en | wa_lock;  // Sticky
         phcomp_wren_d1 <= phcomp_wren_d0;
         phcomp_wren_d2 <= phcomp_wren_d1;
      end
   end

   assign phcomp_wren = phcomp_wren_d2;
   assign wr_en       = phcomp_mode & phcomp_wren;

   // ****************************************
   // Read enable, sync plus delay line
   // ****************************************
   aib_bitsync wren_sync0 (
      .clk      (rd_clk),
      .rd_rst_n (rd_rst_n),
      .data_in  (phcomp_wren),
      .data_out (phcomp_wren_sync2)
   );

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n)
         wren_sync_q <= '0;
      else
         wren_sync_q <= {wren_sync_q[6:3], phcomp_wren_sync2};
   end

   always_comb begin
      case (r_phcomp_rd_delay)
         4'd3:    phcomp_rden = wren_sync_q[3];
         4'd4:    phcomp_rden = wren_sync_q[4];
         4'd5:    phcomp_rden = wren_sync_q[5];
         4'd6:    phcomp_rden = wren_sync_q[6];
         4'd7:    phcomp_rden = wren_sync_q[7];
         default: phcomp_rden = phcomp_wren_sync2;  // Two stages
      endcase
   end

   assign rd_en = phcomp_mode & phcomp_rden;

   aib_adaptrxdp_async_fifo rx_async_fifo0 (
      .wr_clk      (wr_clk),
      .wr_rst_n    (wr_rst_n),
      .wr_en       (wr_en),
      .wr_data     (fifo_din),
      .rd_clk      (rd_clk),
      .rd_rst_n    (rd_rst_n),
      .rd_en       (rd_en),
      .rd_data     (fifo_rd_data),
      .r_wa_en     (r_wa_en),
      .r_mkbit     (r_mkbit),
      .r_fifo_mode (r_fifo_mode),
      .r_empty     (r_empty),
      .r_pempty    (r_pempty),
      .r_full      (r_full),
      .r_pfull     (r_pfull),
      .wa_lock     (wa_lock),
      .wr_full     (fifo_full),
      .wr_pfull    (fifo_pfull),
      .rd_empty    (fifo_empty),
      .rd_pempty   (fifo_pempty)
   );

   // ****************************************
   // Output register and align_done
   // ****************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         data_out   <= '0;
         align_done <= 1'b0;
      end else begin
         align_done <= rd_en;
         if (rd_en)
            data_out <= fifo_rd_data;
         else if (phcomp_mode)
            data_out <= '0;                   // Idle phase-comp clears
      end
   end

   assign fifo_dout = data_out;

   // ****************************************
   // Word align checker
   // ****************************************
   always_comb begin
      for (int i = 0; i < `RXDP_LANES; i++)
         lane_mk[i] = data_out[i*`RXDP_DWIDTH + r_mkbit];
   end

   assign bad_2x = ~(lane_mk[1] & ~lane_mk[0]);
   assign bad_4x = ~(lane_mk[3] & ~|lane_mk[2:0]);

   always_comb begin
      wa_error_int = 1'b0;
      if (r_wa_en && align_done) begin
         if (r_fifo_mode == `RXDP_MODE_2X)
            wa_error_int = bad_2x;
         else if (r_fifo_mode == `RXDP_MODE_4X)
            wa_error_int = bad_4x;
      end
   end

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         wa_error     <= 1'b0;
         wa_error_cnt <= '0;
      end else begin
         wa_error <= wa_error | wa_error_int;        // Sticky
         if (wa_error_int && wa_error_cnt != 4'hf)
            wa_error_cnt <= wa_error_cnt + 4'd1;     // Saturates at 15
      end
   end

   a_errcnt_mono: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      wa_error_cnt >= $past(wa_error_cnt))
      else $error("wa_error_cnt decreased");

   a_reg_mode_idle: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      (r_fifo_mode == `RXDP_MODE_REG) |-> !rd_en ##1 !align_done)
      else $error("Read enable seen in register mode");

endmodule

// File: aib_adaptrxdp_async_fifo.sv
// Dual-clock phase-compensation FIFO for the receive datapath
// Packs 1, 2 or 4 words per entry, locks on a marker bit and
// computes threshold flags in each clock domain
`timescale 1ns/1ps
`include "rxdp_defs.svh"

module aib_adaptrxdp_async_fifo (
   input  logic                 wr_clk,       // Write clock
   input  logic                 wr_rst_n,     // Write reset
   input  logic                 wr_en,        // Take a word every cycle
   input  rxdp_pkg::word_t      wr_data,      // Incoming word
   input  logic                 rd_clk,       // Read clock
   input  logic                 rd_rst_n,     // Read reset
   input  logic                 rd_en,        // Pop an entry every cycle
   output rxdp_pkg::entry_t     rd_data,      // Head entry
   input  logic                 r_wa_en,      // Word align enable
   input  rxdp_pkg::mkbit_t     r_mkbit,      // Marker bit index
   input  rxdp_pkg::fifo_mode_t r_fifo_mode,  // Rate mode
   input  rxdp_pkg::thr_t       r_empty,      // Empty threshold
   input  rxdp_pkg::thr_t       r_pempty,     // Partial empty threshold
   input  rxdp_pkg::thr_t       r_full,       // Full threshold
   input  rxdp_pkg::thr_t       r_pfull,      // Partial full threshold
   output logic                 wa_lock,      // Marker seen, wr_clk domain
   output logic                 wr_full,      // Write-side fill at or above r_full
   output logic                 wr_pfull,     // Write-side fill at or above r_pfull
   output logic                 rd_empty,     // Read-side fill at or below r_empty
   output logic                 rd_pempty     // Read-side fill at or below r_pempty
);

   import rxdp_pkg::*;

   localparam int AW = `RXDP_AWIDTH;
   localparam int DW = `RXDP_DWIDTH;

   entry_t       mem [2**AW];                 // Entry storage
   entry_t       pack_q;                      // Lanes filled so far
   entry_t       pack_next;                   // Group with current word placed
   logic [1:0]   lane_cnt;                    // Next free lane
   logic [1:0]   top_lane;                    // Last lane of the mode
   logic [1:0]   put_lane;                    // Lane for the current word
   logic         wr_mark;                     // Marker on current word
   logic         wr_take;                     // Word accepted
   logic         grp_done;                    // Current word closes the group
   logic         wr_push;                     // Entry written this cycle
   logic [AW:0]  wr_bin, wr_bin_nxt, wr_gray; // Write pointer
   logic [AW:0]  rd_bin, rd_bin_nxt, rd_gray; // Read pointer
   logic [AW:0]  wr_gray_rs;                  // Write pointer in rd_clk
   logic [AW:0]  rd_gray_ws;                  // Read pointer in wr_clk
   logic [AW:0]  rd_fill;                     // Fill seen by read side
   logic [AW:0]  wr_fill;                     // Fill seen by write side
   logic [AW:0]  true_fill;                   // Exact fill for checks

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--)
         b[i] = b[i+1] ^ g[i];
      return b;
   endfunction

   // ****************************************
   // Write side lane packer
   // ****************************************
   always_comb begin
      case (r_fifo_mode)
         `RXDP_MODE_2X: top_lane = 2'd1;
         `RXDP_MODE_4X: top_lane = 2'd3;
         default:       top_lane = 2'd0;     // 1x and register mode
      endcase
   end

   assign wr_mark  = r_wa_en & wr_data[r_mkbit];
   assign wr_take  = wr_en & (wa_lock | ~r_wa_en);    // Nothing before lock
   assign put_lane = wr_mark ? top_lane : lane_cnt;   // Marker goes to top lane
   assign grp_done = wr_mark | (lane_cnt == top_lane);
   assign wr_push  = wr_take & grp_done;

   always_comb begin
      pack_next = pack_q;
      pack_next[put_lane*DW +: DW] = wr_data;
   end

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         lane_cnt <= 2'd0;
         pack_q   <= '0;
         wa_lock  <= 1'b0;
      end else begin
         if (wr_mark)
            wa_lock <= 1'b1;                  // Sticky lock
         if (wr_push) begin
            lane_cnt <= 2'd0;
            pack_q   <= '0;                   // Unfilled lanes stay zero
         end else if (wr_take) begin
            lane_cnt <= lane_cnt + 2'd1;
            pack_q   <= pack_next;
         end
      end
   end

   // ****************************************
   // Memory and pointers
   // ****************************************
   always_ff @(posedge wr_clk) begin
      if (wr_push)
         mem[wr_bin[AW-1:0]] <= pack_next;
   end

   assign wr_bin_nxt = wr_bin + 1'b1;
   assign rd_bin_nxt = rd_bin + 1'b1;

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else if (wr_push) begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
      end
   end

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else if (rd_en) begin               // No back-pressure
         rd_bin  <= rd_bin_nxt;
         rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      end
   end

   assign rd_data = mem[rd_bin[AW-1:0]];

   aib_bitsync #(.WIDTH(AW + 1)) wptr_sync0 (
      .clk      (rd_clk),
      .rd_rst_n (rd_rst_n),
      .data_in  (wr_gray),
      .data_out (wr_gray_rs)
   );

   aib_bitsync #(.WIDTH(AW + 1)) rptr_sync0 (
      .clk      (wr_clk),
      .rd_rst_n (wr_rst_n),
      .data_in  (rd_gray),
      .data_out (rd_gray_ws)
   );

   // ****************************************
   // Threshold flags
   // ****************************************
   assign rd_fill   = gray2bin(wr_gray_rs) - rd_bin;
   assign wr_fill   = wr_bin - gray2bin(rd_gray_ws);
   assign rd_empty  = rd_fill <= {1'b0, r_empty};
   assign rd_pempty = rd_fill <= {1'b0, r_pempty};
   assign wr_full   = wr_fill >= {1'b0, r_full};
   assign wr_pfull  = wr_fill >= {1'b0, r_pfull};

   // Exact pointer distance across both domains
   assign true_fill = wr_bin - rd_bin;

   a_no_overwrite: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      wr_push |-> (true_fill != (AW + 1)'(2**AW)))
      else $error("FIFO write would overwrite an unread entry");

   a_no_empty_read: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      rd_en |-> (true_fill != '0))
      else $error("FIFO read of an empty memory");

endmodule

// File: aib_bitsync.sv
// Two-flop level synchronizer
// WIDTH bits move in parallel, so multi-bit use needs Gray-coded input
`timescale 1ns/1ps

module aib_bitsync #(
   parameter int WIDTH = 1                // Bits synchronized side by side
) (
   input  logic             clk,          // Destination clock
   input  logic             rd_rst_n,     // Destination reset, sync active low
   input  logic [WIDTH-1:0] data_in,      // Source domain level
   output logic [WIDTH-1:0] data_out      // Level in clk domain
);

   logic [WIDTH-1:0] meta_q;              // First stage, may go metastable

   always_ff @(posedge clk) begin
      if (!rd_rst_n) begin
         meta_q   <= '0;
         data_out <= '0;
      end else begin
         meta_q   <= data_in;             // Capture
         data_out <= meta_q;              // Resolve
      end
   end

endmodule

// File: rxdp_pkg.sv
// Receive datapath types
// Vector typedefs for words, entries and configuration fields
`include "rxdp_defs.svh"

package rxdp_pkg;

   // ****************************************
   // Payload types
   // ****************************************
   typedef logic [`RXDP_DWIDTH-1:0]             word_t;   // One link word
   typedef logic [`RXDP_LANES*`RXDP_DWIDTH-1:0] entry_t;  // Four lanes, lane 0 low

   // ****************************************
   // Configuration and status types
   // ****************************************
   typedef logic [1:0]              fifo_mode_t;  // Rate mode code
   typedef logic [`RXDP_AWIDTH-1:0] thr_t;        // Fill threshold
   typedef logic [6:0]              mkbit_t;      // Marker bit index in a word
   typedef logic [3:0]              rd_delay_t;   // Read delay tap select
   typedef logic [3:0]              errcnt_t;     // Saturating error count

endpackage

// File: rxdp_defs.svh
// Receive datapath build constants
// Word width, lane count, FIFO depth and rate-mode codes
`ifndef RXDP_DEFS_SVH
`define RXDP_DEFS_SVH

// ****************************************
// Datapath geometry
// ****************************************
`define RXDP_DWIDTH 80   // Bits per link word
`define RXDP_LANES  4    // Word lanes per read entry
`define RXDP_AWIDTH 4    // FIFO address bits, 16 entries

// Rate-mode codes on r_fifo_mode
`define RXDP_MODE_1X  2'd0   // Full rate, one word per entry
`define RXDP_MODE_2X  2'd1   // Half rate, two words per entry
`define RXDP_MODE_4X  2'd2   // Quarter rate, four words per entry
`define RXDP_MODE_REG 2'd3   // Register mode, FIFO idle

`endif
